// ==== hdl/clic_pkg.sv ====
// word and address types, csr opcodes, entry struct, sizes and csr addresses
package clic_pkg;

  // core data word
  typedef logic [31:0] word;

  // csr address space is 12 bits wide
  typedef logic [11:0] csr_addr_t;

  // operations a csr access can apply
  typedef enum logic [1:0] {
    csr_none = 2'd0,
    csr_rw   = 2'd1,
    csr_rs   = 2'd2,
    csr_rc   = 2'd3
  } csr_op_t;

  // vector and priority sizing
  localparam int vec_size    = 8;
  localparam int vec_width   = 3;
  localparam int prio_levels = 8;
  localparam int prio_width  = 3;

  // handler and return addresses
  localparam int imem_addr_width = 16;

  // one stack slot per priority level, enough for full nesting
  localparam int stack_depth = prio_levels;

  // control csrs
  localparam csr_addr_t mstatus_addr     = 12'h305;
  localparam csr_addr_t mintthresh_addr  = 12'h347;
  localparam csr_addr_t stack_depth_addr = 12'h350;

  // per-vector csr blocks, vector k sits at base + k
  localparam csr_addr_t vec_csr_base   = 12'hb00;
  localparam csr_addr_t entry_csr_base = 12'hb20;

  // entry csr layout, pended is the lsb
  typedef struct packed {
    logic [prio_width-1:0] prio;
    logic                  enabled;
    logic                  pended;
  } entry_t;

endpackage

// ==== hdl/csr_bus_if.sv ====
// csr access bus with issuing and receiving modports
`timescale 1ns/1ps

interface csr_bus_if;

  logic                en;
  clic_pkg::csr_addr_t addr;
  clic_pkg::csr_op_t   op;
  clic_pkg::word       wdata;
  // read data back to the issuer
  clic_pkg::word       rdata;

  modport master (
    output en,
    output addr,
    output op,
    output wdata,
    input  rdata
  );

  modport slave (
    input en,
    input addr,
    input op,
    input wdata
  );

endinterface

// ==== hdl/csr_reg.sv ====
// single csr with address match, rw/set/clear update and hardware write port
`timescale 1ns/1ps

module csr_reg #(
  parameter int                  width       = 32,
  parameter clic_pkg::csr_addr_t addr        = '0,
  parameter clic_pkg::word       reset_value = '0,
  parameter bit                  writable    = 1'b1
) (
  input  logic            clk,
  input  logic            rst_n,
  csr_bus_if.slave        bus,
  input  logic            hw_we,
  input  clic_pkg::word   hw_data,
  output clic_pkg::word   data
);

  logic [width-1:0] value;
  logic [width-1:0] operand;
  logic             hit;

  // read-only instances never respond to software writes
  assign hit     = writable && bus.en && (bus.addr == addr);
  assign operand = bus.wdata[width-1:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      value <= reset_value[width-1:0];
    end else if (hw_we) begin
      // hardware update wins over a software access in the same cycle
      value <= hw_data[width-1:0];
    end else if (hit) begin
      case (bus.op)
        clic_pkg::csr_rw: value <= operand;
        clic_pkg::csr_rs: value <= value | operand;
        clic_pkg::csr_rc: value <= value & ~operand;
        default: value <= value;
      endcase
    end
  end

  // bits above width read as zero
  assign data = clic_pkg::word'(value);

endmodule

// ==== hdl/prio_arbiter.sv ====
// chained maximum-priority search over vector entries against a threshold
`timescale 1ns/1ps

module prio_arbiter (
  input  clic_pkg::entry_t                entries [clic_pkg::vec_size],
  input  logic [clic_pkg::prio_width-1:0] thresh,
  output logic                            req,
  output logic [clic_pkg::vec_width-1:0]  vec,
  output logic [clic_pkg::prio_width-1:0] prio
);

  logic [clic_pkg::prio_width-1:0] best_prio;
  logic [clic_pkg::vec_width-1:0]  best_vec;
  logic                            found;

  // running maximum starts at the threshold, so only strictly higher
  // priorities can ever win
  always_comb begin
    best_prio = thresh;
    best_vec  = '0;
    found     = 1'b0;
    for (int k = 0; k < clic_pkg::vec_size; k++) begin
      // strict compare keeps ties on the lowest index
      if (entries[k].enabled && entries[k].pended && (entries[k].prio > best_prio)) begin
        best_prio = entries[k].prio;
        best_vec  = k[clic_pkg::vec_width-1:0];
        found     = 1'b1;
      end
    end
  end

  assign req  = found;
  assign vec  = best_vec;
  // equals thresh when nothing requests
  assign prio = best_prio;

endmodule

// ==== hdl/epc_stack.sv ====
// lifo of return address and saved threshold with depth count
`timescale 1ns/1ps

module epc_stack (
  input  logic                                                   clk,
  input  logic                                                   rst_n,
  input  logic                                                   push,
  input  logic                                                   pop,
  input  logic [clic_pkg::imem_addr_width+clic_pkg::prio_width-1:0] data_in,
  output logic [clic_pkg::imem_addr_width+clic_pkg::prio_width-1:0] data_out,
  output logic [clic_pkg::vec_width:0]                           depth
);

  logic [clic_pkg::imem_addr_width+clic_pkg::prio_width-1:0] slots [clic_pkg::stack_depth];
  logic [clic_pkg::vec_width-1:0] wr_idx;
  logic [clic_pkg::vec_width-1:0] top_idx;
  logic                           full;
  logic                           empty;

  assign full    = (int'(depth) == clic_pkg::stack_depth);
  assign empty   = (depth == '0);
  assign wr_idx  = depth[clic_pkg::vec_width-1:0];
  assign top_idx = wr_idx - 1'b1;

  // slot storage
  always_ff @(posedge clk) begin
    if (push && !full) begin
      slots[wr_idx] <= data_in;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      depth <= '0;
    end else if (push && !full) begin
      depth <= depth + 1'b1;
    end else if (pop && !empty) begin
      depth <= depth - 1'b1;
    end
  end

  // top of stack, valid before the pop edge
  assign data_out = empty ? '0 : slots[top_idx];

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
    else $error("epc stack push while full");
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty)
    else $error("epc stack pop while empty");
  a_no_push_pop: assert property (@(posedge clk) disable iff (!rst_n) !(push && pop))
    else $error("epc stack push and pop in one cycle");

endmodule

// ==== hdl/n_clic.sv ====
// interrupt controller core: csr bank, pending logic, arbiter and epc stack
`timescale 1ns/1ps

module n_clic (
  input  logic                                 clk,
  input  logic                                 rst_n,
  csr_bus_if.slave                             csr,
  output clic_pkg::word                        rdata,
  input  logic [clic_pkg::vec_size-1:0]        irq,
  output logic                                 int_req,
  output logic [clic_pkg::vec_width-1:0]       int_vec,
  output logic [clic_pkg::prio_width-1:0]      int_prio,
  output logic [clic_pkg::imem_addr_width-1:0] int_addr,
  input  logic                                 int_take,
  input  logic                                 int_return,
  input  logic [clic_pkg::imem_addr_width-1:0] epc_in,
  output logic [clic_pkg::imem_addr_width-1:0] epc_out
);

  clic_pkg::word    mstatus_data;
  clic_pkg::word    thresh_data;
  clic_pkg::word    depth_data;
  clic_pkg::word    vec_data   [clic_pkg::vec_size];
  clic_pkg::word    entry_data [clic_pkg::vec_size];
  clic_pkg::word    entry_hw   [clic_pkg::vec_size];
  logic [clic_pkg::vec_size-1:0] entry_we;
  clic_pkg::entry_t entries    [clic_pkg::vec_size];

  logic [clic_pkg::prio_width-1:0] thresh;
  logic [clic_pkg::prio_width-1:0] thresh_next;
  logic [clic_pkg::vec_width:0]    depth;
  logic [clic_pkg::vec_width:0]    depth_next;
  logic [clic_pkg::imem_addr_width+clic_pkg::prio_width-1:0] top_slot;

  // take raises to the winner's priority, return restores the saved one
  assign thresh      = thresh_data[clic_pkg::prio_width-1:0];
  assign thresh_next = int_take ? int_prio : top_slot[clic_pkg::prio_width-1:0];
  // depth csr follows the stack at the same edge
  assign depth_next  = int_take ? depth + 1'b1 : depth - 1'b1;

  csr_reg #(.width(32), .addr(clic_pkg::mstatus_addr), .reset_value('0),
            .writable(1'b1)) mstatus_i (
    .clk, .rst_n, .bus(csr),
    .hw_we(1'b0), .hw_data('0), .data(mstatus_data)
  );

  csr_reg #(.width(clic_pkg::prio_width), .addr(clic_pkg::mintthresh_addr),
            .reset_value('0), .writable(1'b1)) thresh_i (
    .clk, .rst_n, .bus(csr),
    .hw_we(int_take || int_return), .hw_data(clic_pkg::word'(thresh_next)),
    .data(thresh_data)
  );

  csr_reg #(.width(clic_pkg::vec_width + 1), .addr(clic_pkg::stack_depth_addr),
            .reset_value('0), .writable(1'b0)) depth_i (
    .clk, .rst_n, .bus(csr),
    .hw_we(int_take || int_return), .hw_data(clic_pkg::word'(depth_next)),
    .data(depth_data)
  );

  for (genvar k = 0; k < clic_pkg::vec_size; k++) begin : gen_vec
    logic hit;
    logic take;

    csr_reg #(.width(clic_pkg::imem_addr_width),
              .addr(clic_pkg::csr_addr_t'(clic_pkg::vec_csr_base + k)),
              .reset_value('0), .writable(1'b1)) vec_i (
      .clk, .rst_n, .bus(csr),
      .hw_we(1'b0), .hw_data('0), .data(vec_data[k])
    );

    csr_reg #(.width($bits(clic_pkg::entry_t)),
              .addr(clic_pkg::csr_addr_t'(clic_pkg::entry_csr_base + k)),
              .reset_value('0), .writable(1'b1)) entry_i (
      .clk, .rst_n, .bus(csr),
      .hw_we(entry_we[k]), .hw_data(entry_hw[k]), .data(entry_data[k])
    );

    assign entries[k] = clic_pkg::entry_t'(entry_data[k][$bits(clic_pkg::entry_t)-1:0]);
    assign hit  = csr.en && (csr.op != clic_pkg::csr_none) &&
                  (csr.addr == clic_pkg::csr_addr_t'(clic_pkg::entry_csr_base + k));
    assign take = int_take && (int'(int_vec) == k);

    // a software write to the entry holds off the irq for one cycle
    assign entry_we[k] = take || (irq[k] && !hit);
    assign entry_hw[k] = clic_pkg::word'({entries[k].prio, entries[k].enabled, !take});
  end

  // one-hot read select, unmapped addresses read zero
  always_comb begin
    rdata = '0;
    if (csr.en) begin
      if (csr.addr == clic_pkg::mstatus_addr) begin
        rdata = mstatus_data;
      end
      if (csr.addr == clic_pkg::mintthresh_addr) begin
        rdata = thresh_data;
      end
      if (csr.addr == clic_pkg::stack_depth_addr) begin
        rdata = depth_data;
      end
      for (int k = 0; k < clic_pkg::vec_size; k++) begin
        if (csr.addr == clic_pkg::csr_addr_t'(clic_pkg::vec_csr_base + k)) begin
          rdata = vec_data[k];
        end
        if (csr.addr == clic_pkg::csr_addr_t'(clic_pkg::entry_csr_base + k)) begin
          rdata = entry_data[k];
        end
      end
    end
  end

  prio_arbiter arbiter_i (
    .entries, .thresh, .req(int_req), .vec(int_vec), .prio(int_prio)
  );

  // handler of the current winner
  assign int_addr = vec_data[int_vec][clic_pkg::imem_addr_width-1:0];

  epc_stack stack_i (
    .clk, .rst_n, .push(int_take), .pop(int_return),
    .data_in({epc_in, thresh}), .data_out(top_slot), .depth
  );

  assign epc_out = top_slot[clic_pkg::imem_addr_width+clic_pkg::prio_width-1:clic_pkg::prio_width];

  a_take_with_req: assert property (@(posedge clk) disable iff (!rst_n) int_take |-> int_req)
    else $error("interrupt taken without a pending request");

endmodule

// ==== hdl/clic_top.sv ====
// top level with plain csr ports bundled onto the csr bus for the clic core
`timescale 1ns/1ps

module clic_top (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 csr_en,
  input  clic_pkg::csr_addr_t                  csr_addr,
  input  clic_pkg::csr_op_t                    csr_op,
  input  clic_pkg::word                        csr_wdata,
  output clic_pkg::word                        csr_rdata,
  input  logic [clic_pkg::vec_size-1:0]        irq,
  output logic                                 int_req,
  output logic [clic_pkg::vec_width-1:0]       int_vec,
  output logic [clic_pkg::prio_width-1:0]      int_prio,
  output logic [clic_pkg::imem_addr_width-1:0] int_addr,
  input  logic                                 int_take,
  input  logic                                 int_return,
  input  logic [clic_pkg::imem_addr_width-1:0] epc_in,
  output logic [clic_pkg::imem_addr_width-1:0] epc_out
);

  clic_pkg::word clic_rdata;

  csr_bus_if bus_i ();

  // core side of the bus
  assign bus_i.en    = csr_en;
  assign bus_i.addr  = csr_addr;
  assign bus_i.op    = csr_op;
  assign bus_i.wdata = csr_wdata;
  assign bus_i.rdata = clic_rdata;
  assign csr_rdata   = bus_i.rdata;

  n_clic clic_i (
    .clk, .rst_n,
    .csr(bus_i),
    .rdata(clic_rdata),
    .irq,
    .int_req, .int_vec, .int_prio, .int_addr,
    .int_take, .int_return,
    .epc_in, .epc_out
  );

endmodule

// ==== tb/tb_clic.sv ====
// directed testbench for clic_top with reference model, compare tasks and watchdog
`timescale 1ns/1ps

module tb_clic;

  localparam int clk_period = 4;
  localparam int reset_cycles = 3;
  // per-test cycle budgets summed for the watchdog
  localparam int budget_cycles = 60 + 120 + 80 + 80 + 80;
  localparam int margin_ns = 200;
  localparam int slot_width = clic_pkg::imem_addr_width + clic_pkg::prio_width;

  logic clk;
  logic rst_n;
  logic csr_en;
  clic_pkg::csr_addr_t csr_addr;
  clic_pkg::csr_op_t csr_op;
  clic_pkg::word csr_wdata;
  clic_pkg::word csr_rdata;
  logic [clic_pkg::vec_size-1:0] irq;
  logic int_req;
  logic [clic_pkg::vec_width-1:0] int_vec;
  logic [clic_pkg::prio_width-1:0] int_prio;
  logic [clic_pkg::imem_addr_width-1:0] int_addr;
  logic int_take;
  logic int_return;
  logic [clic_pkg::imem_addr_width-1:0] epc_in;
  logic [clic_pkg::imem_addr_width-1:0] epc_out;

  // reference model
  clic_pkg::entry_t ref_entry [clic_pkg::vec_size];
  logic [clic_pkg::imem_addr_width-1:0] ref_handler [clic_pkg::vec_size];
  logic [clic_pkg::prio_width-1:0] ref_thresh;
  logic [slot_width-1:0] ref_stack [$];
  int checks;
  int errors;
  int errors_at_start;

  clic_top dut_i (
    .clk, .rst_n, .csr_en, .csr_addr, .csr_op, .csr_wdata, .csr_rdata,
    .irq, .int_req, .int_vec, .int_prio, .int_addr,
    .int_take, .int_return, .epc_in, .epc_out
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #((reset_cycles + budget_cycles) * clk_period + margin_ns);
    $display("watchdog expired before the tests finished");
    $display("Test FAILED");
    $finish;
  end

  task automatic check_word(string what, clic_pkg::word got, clic_pkg::word exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_vec(string what, logic [clic_pkg::vec_width-1:0] got,
                           logic [clic_pkg::vec_width-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(string what, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic csr_write(clic_pkg::csr_addr_t addr, clic_pkg::csr_op_t op,
                           clic_pkg::word data);
    @(posedge clk);
    csr_en <= 1'b1;
    csr_addr <= addr;
    csr_op <= op;
    csr_wdata <= data;
    @(posedge clk);
    csr_en <= 1'b0;
    csr_op <= clic_pkg::csr_none;
  endtask

  // read data is combinational and sampled mid-cycle
  task automatic csr_read(clic_pkg::csr_addr_t addr, output clic_pkg::word data);
    @(posedge clk);
    csr_en <= 1'b1;
    csr_addr <= addr;
    csr_op <= clic_pkg::csr_none;
    @(negedge clk);
    data = csr_rdata;
  endtask

  task automatic check_csr(string what, clic_pkg::csr_addr_t addr, clic_pkg::word exp);
    clic_pkg::word got;
    csr_read(addr, got);
    check_word(what, got, exp);
  endtask

  task automatic write_entry(int k, int prio, bit enabled, bit pended);
    clic_pkg::entry_t e;
    e.prio    = prio[clic_pkg::prio_width-1:0];
    e.enabled = enabled;
    e.pended  = pended;
    csr_write(clic_pkg::csr_addr_t'(clic_pkg::entry_csr_base + k), clic_pkg::csr_rw,
              clic_pkg::word'(e));
    ref_entry[k] = e;
  endtask

  // find the highest candidate priority and then the lowest index holding it
  task automatic expected_winner(output logic req, output logic [clic_pkg::vec_width-1:0] vec,
                                 output logic [clic_pkg::prio_width-1:0] prio);
    int top;
    top = -1;
    req = 1'b0;
    vec = '0;
    prio = ref_thresh;
    for (int k = 0; k < clic_pkg::vec_size; k++) begin
      if (ref_entry[k].enabled && ref_entry[k].pended && ref_entry[k].prio > ref_thresh &&
          int'(ref_entry[k].prio) > top) begin
        top = ref_entry[k].prio;
      end
    end
    for (int k = clic_pkg::vec_size - 1; k >= 0; k--) begin
      if (ref_entry[k].enabled && ref_entry[k].pended && int'(ref_entry[k].prio) == top) begin
        req = 1'b1;
        vec = k[clic_pkg::vec_width-1:0];
        prio = ref_entry[k].prio;
      end
    end
  endtask

  task automatic check_arbitration();
    logic exp_req;
    logic [clic_pkg::vec_width-1:0] exp_vec;
    logic [clic_pkg::prio_width-1:0] exp_prio;
    expected_winner(exp_req, exp_vec, exp_prio);
    @(negedge clk);
    check_flag("int_req", int_req, exp_req);
    if (exp_req) begin
      check_vec("int_vec", int_vec, exp_vec);
      check_word("int_prio", clic_pkg::word'(int_prio), clic_pkg::word'(exp_prio));
      check_word("int_addr", clic_pkg::word'(int_addr), clic_pkg::word'(ref_handler[exp_vec]));
    end
  endtask

  task automatic take_irq(logic [clic_pkg::imem_addr_width-1:0] epc);
    logic exp_req;
    logic [clic_pkg::vec_width-1:0] exp_vec;
    logic [clic_pkg::prio_width-1:0] exp_prio;
    expected_winner(exp_req, exp_vec, exp_prio);
    @(negedge clk);
    check_flag("int_req before take", int_req, 1'b1);
    check_vec("int_vec before take", int_vec, exp_vec);
    if (exp_req && int_req === 1'b1) begin
      @(posedge clk);
      int_take <= 1'b1;
      epc_in <= epc;
      @(posedge clk);
      int_take <= 1'b0;
      ref_stack.push_back({epc, ref_thresh});
      ref_thresh = exp_prio;
      ref_entry[exp_vec].pended = 1'b0;
    end
  endtask

  task automatic return_irq();
    logic [slot_width-1:0] top;
    top = ref_stack.pop_back();
    @(negedge clk);
    check_word("epc_out", clic_pkg::word'(epc_out),
               clic_pkg::word'(top[slot_width-1:clic_pkg::prio_width]));
    @(posedge clk);
    int_return <= 1'b1;
    @(posedge clk);
    int_return <= 1'b0;
    ref_thresh = top[clic_pkg::prio_width-1:0];
  endtask

  task automatic check_levels();
    check_csr("mintthresh", clic_pkg::mintthresh_addr, clic_pkg::word'(ref_thresh));
    check_csr("stack depth", clic_pkg::stack_depth_addr, clic_pkg::word'(ref_stack.size()));
  endtask

  task automatic report(string name);
    $display("%s %s, %0d errors", name, (errors == errors_at_start) ? "passed" : "failed",
             errors - errors_at_start);
    errors_at_start = errors;
  endtask

  task automatic reset_and_csr_ops();
    for (int k = 0; k < clic_pkg::vec_size; k++) begin
      check_csr("vec after reset", clic_pkg::csr_addr_t'(clic_pkg::vec_csr_base + k), '0);
      check_csr("entry after reset", clic_pkg::csr_addr_t'(clic_pkg::entry_csr_base + k), '0);
    end
    check_csr("mstatus after reset", clic_pkg::mstatus_addr, '0);
    check_levels();
    check_arbitration();
    csr_write(clic_pkg::mstatus_addr, clic_pkg::csr_rw, 32'ha5a5_0f0f);
    check_csr("mstatus rw", clic_pkg::mstatus_addr, 32'ha5a5_0f0f);
    csr_write(clic_pkg::mstatus_addr, clic_pkg::csr_rs, 32'h0000_f000);
    check_csr("mstatus rs", clic_pkg::mstatus_addr, 32'ha5a5_ff0f);
    csr_write(clic_pkg::mstatus_addr, clic_pkg::csr_rc, 32'h0000_0005);
    check_csr("mstatus rc", clic_pkg::mstatus_addr, 32'ha5a5_ff0a);
    csr_write(clic_pkg::mintthresh_addr, clic_pkg::csr_rw, 32'hffff_fffd);
    check_csr("mintthresh rw", clic_pkg::mintthresh_addr, 32'd5);
    csr_write(clic_pkg::mintthresh_addr, clic_pkg::csr_rs, 32'd2);
    check_csr("mintthresh rs", clic_pkg::mintthresh_addr, 32'd7);
    csr_write(clic_pkg::mintthresh_addr, clic_pkg::csr_rc, 32'd5);
    check_csr("mintthresh rc", clic_pkg::mintthresh_addr, 32'd2);
    csr_write(clic_pkg::mintthresh_addr, clic_pkg::csr_rw, 32'd0);
    csr_write(clic_pkg::stack_depth_addr, clic_pkg::csr_rw, 32'd5);
    check_levels();
    check_csr("unmapped", 12'h123, '0);
    report("reset_csr");
  endtask

  task automatic table_readback();
    clic_pkg::word rnd;
    for (int k = 0; k < clic_pkg::vec_size; k++) begin
      rnd = $urandom;
      csr_write(clic_pkg::csr_addr_t'(clic_pkg::vec_csr_base + k), clic_pkg::csr_rw, rnd);
      ref_handler[k] = rnd[clic_pkg::imem_addr_width-1:0];
      rnd = $urandom;
      csr_write(clic_pkg::csr_addr_t'(clic_pkg::entry_csr_base + k), clic_pkg::csr_rw, rnd);
      ref_entry[k] = rnd[$bits(clic_pkg::entry_t)-1:0];
    end
    for (int k = 0; k < clic_pkg::vec_size; k++) begin
      check_csr("vec readback", clic_pkg::csr_addr_t'(clic_pkg::vec_csr_base + k),
                clic_pkg::word'(ref_handler[k]));
      check_csr("entry readback", clic_pkg::csr_addr_t'(clic_pkg::entry_csr_base + k),
                clic_pkg::word'(ref_entry[k]));
    end
    check_arbitration();
    for (int k = 0; k < clic_pkg::vec_size; k++) begin
      write_entry(k, 0, 1'b0, 1'b0);
    end
    report("table");
  endtask

  task automatic arbitration_order();
    write_entry(1, 3, 1'b1, 1'b1);
    write_entry(2, 6, 1'b1, 1'b1);
    write_entry(5, 6, 1'b1, 1'b1);
    write_entry(6, 2, 1'b1, 1'b1);
    // highest priorities but either disabled or not pending
    write_entry(3, 7, 1'b0, 1'b1);
    write_entry(4, 7, 1'b1, 1'b0);
    check_arbitration();
    check_vec("tie to lowest index", int_vec, 3'd2);
    csr_write(clic_pkg::mintthresh_addr, clic_pkg::csr_rw, 32'd6);
    ref_thresh = 3'd6;
    check_arbitration();
    csr_write(clic_pkg::mintthresh_addr, clic_pkg::csr_rw, 32'd5);
    ref_thresh = 3'd5;
    check_arbitration();
    csr_write(clic_pkg::mintthresh_addr, clic_pkg::csr_rw, 32'd0);
    ref_thresh = 3'd0;
    for (int k = 0; k < clic_pkg::vec_size; k++) begin
      write_entry(k, 0, 1'b0, 1'b0);
    end
    check_arbitration();
    report("arbitration");
  endtask

  task automatic irq_pending();
    write_entry(4, 5, 1'b1, 1'b0);
    write_entry(7, 3, 1'b1, 1'b0);
    check_arbitration();
    @(posedge clk);
    irq <= 8'h90;
    @(posedge clk);
    irq <= '0;
    ref_entry[4].pended = 1'b1;
    ref_entry[7].pended = 1'b1;
    check_csr("entry 4 pended", clic_pkg::csr_addr_t'(clic_pkg::entry_csr_base + 4),
              clic_pkg::word'(ref_entry[4]));
    check_arbitration();
    take_irq(16'h1234);
    check_csr("entry 4 after take", clic_pkg::csr_addr_t'(clic_pkg::entry_csr_base + 4),
              clic_pkg::word'(ref_entry[4]));
    check_arbitration();
    return_irq();
    check_levels();
    // with the threshold back at zero vector 7 is next in line
    check_arbitration();
    write_entry(7, 0, 1'b0, 1'b0);
    write_entry(4, 0, 1'b0, 1'b0);
    report("irq_lines");
  endtask

  task automatic nested_return();
    write_entry(1, 2, 1'b1, 1'b1);
    take_irq(16'h0100);
    check_levels();
    write_entry(6, 6, 1'b1, 1'b1);
    check_arbitration();
    take_irq(16'h0600);
    check_levels();
    check_arbitration();
    return_irq();
    check_levels();
    return_irq();
    check_levels();
    report("nesting");
  endtask

  initial begin
    void'($urandom(32'h6755_188b));
    checks = 0;
    errors = 0;
    errors_at_start = 0;
    ref_thresh = '0;
    for (int k = 0; k < clic_pkg::vec_size; k++) begin
      ref_entry[k] = '0;
      ref_handler[k] = '0;
    end
    rst_n = 1'b0;
    csr_en = 1'b0;
    csr_addr = '0;
    csr_op = clic_pkg::csr_none;
    csr_wdata = '0;
    irq = '0;
    int_take = 1'b0;
    int_return = 1'b0;
    epc_in = '0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
    reset_and_csr_ops();
    table_readback();
    arbitration_order();
    irq_pending();
    nested_return();
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
hdl/clic_pkg.sv
hdl/csr_bus_if.sv
hdl/csr_reg.sv
hdl/prio_arbiter.sv
hdl/epc_stack.sv
hdl/n_clic.sv
hdl/clic_top.sv
tb/tb_clic.sv

// ==== Makefile ====
# Verilator build and run for the CLIC testbench

VERILATOR ?= verilator
TOP       ?= tb_clic
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean build

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

test: build
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '^Test OK$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
